/* files.f */
source/lsu_pkg.sv
source/lsu_store.sv
source/lsu_lane_ram.sv
source/lsu_load.sv
source/lsu_mem_top.sv
verification/tb_lsu_mem.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and decides the result from the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f files.f \
  --top-module tb_lsu_mem \
  -o tb_lsu_mem

./obj_dir/tb_lsu_mem > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi

/* source/lsu_lane_ram.sv */
// one byte lane of the data memory; contents are undefined until written, read returns old data

module lsu_lane_ram #(
  parameter int ADDR_WD = 6
) (
  input  logic                        i_clk,
  input  logic                        i_we,
  input  logic [ADDR_WD-1:0]          i_waddr,
  input  logic [lsu_pkg::LANE_WD-1:0] i_wdata,
  output logic [lsu_pkg::LANE_WD-1:0] o_rdata
);

  import lsu_pkg::*;

  logic [LANE_WD-1:0] mem [2**ADDR_WD];

  // the same index serves the write and the read port
  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
    o_rdata <= mem[i_waddr];  // a write in the same cycle shows up one edge later
  end

endmodule

/* source/lsu_load.sv */
// load aligner; results appear one cycle after the request, misaligned loads return zero

module lsu_load (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_req,
  input  logic                        i_wen,
  input  lsu_pkg::mem_op_e            i_mem_op,
  input  logic [lsu_pkg::OFS_WD-1:0]  i_offset,
  input  logic                        i_misalign,
  input  logic [lsu_pkg::DATA_WD-1:0] i_rd_word,
  output logic                        o_rvalid,
  output logic [lsu_pkg::DATA_WD-1:0] o_rdata,
  output logic                        o_err
);

  import lsu_pkg::*;

  logic               is_load;
  logic               load_q;
  logic               err_q;
  mem_op_e            op_q;
  logic [OFS_WD-1:0]  ofs_q;
  logic               mis_q;
  logic [DATA_WD-1:0] shifted;
  logic [DATA_WD-1:0] extended;

  assign is_load = i_req && !i_wen && (i_mem_op != MEM_NONE);

  // strobes see a fresh value every cycle so back-to-back loads stream
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      load_q <= 1'b0;
      err_q  <= 1'b0;
    end else begin
      load_q <= is_load;
      err_q  <= i_req && i_misalign;   // stores report misalignment too
    end
  end

  // only meaningful while load_q is set
  always_ff @(posedge i_clk) begin
    op_q  <= i_mem_op;
    ofs_q <= i_offset;
    mis_q <= i_misalign;
  end

  // the RAM word arrives in the cycle after the request, as the registered fields do
  assign shifted = i_rd_word >> {ofs_q, 3'b000};

  always_comb begin
    case (op_q)
      MEM_LB:  extended = {{56{shifted[7]}}, shifted[7:0]};
      MEM_LBU: extended = {56'd0, shifted[7:0]};
      MEM_LH:  extended = {{48{shifted[15]}}, shifted[15:0]};
      MEM_LHU: extended = {48'd0, shifted[15:0]};
      MEM_LW:  extended = {{32{shifted[31]}}, shifted[31:0]};
      MEM_LWU: extended = {32'd0, shifted[31:0]};
      MEM_LD:  extended = shifted;
      default: extended = '0;
    endcase
  end

  assign o_rvalid = load_q;
  assign o_err    = err_q;

  // zero outside a valid cycle, and zero for a misaligned load
  assign o_rdata = (load_q && !mis_q) ? extended : '0;

endmodule

/* source/lsu_mem_top.sv */
// data-memory slice of 2**ADDR_WD words; accesses must be naturally aligned, one per cycle

module lsu_mem_top #(
  parameter int ADDR_WD = 6
) (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic                                i_req,
  input  logic                                i_wen,
  input  lsu_pkg::mem_op_e                    i_mem_op,
  input  logic [ADDR_WD+lsu_pkg::OFS_WD-1:0]  i_addr,
  input  logic [lsu_pkg::DATA_WD-1:0]         i_wdata,
  output logic                                o_rvalid,
  output logic [lsu_pkg::DATA_WD-1:0]         o_rdata,
  output logic                                o_err
);

  import lsu_pkg::*;

  logic [OFS_WD-1:0]   offset;
  logic [ADDR_WD-1:0]  word_idx;
  logic [LANE_NUM-1:0] lane_we;
  logic [DATA_WD-1:0]  lane_wdata;
  logic [DATA_WD-1:0]  rd_word;
  logic                misalign;

  assign offset   = i_addr[OFS_WD-1:0];
  assign word_idx = i_addr[ADDR_WD+OFS_WD-1:OFS_WD];  // every lane sees the same word

  lsu_store u_store (
    .i_req        (i_req),
    .i_wen        (i_wen),
    .i_mem_op     (i_mem_op),
    .i_offset     (offset),
    .i_wdata      (i_wdata),
    .o_lane_we    (lane_we),
    .o_lane_wdata (lane_wdata),
    .o_misalign   (misalign)
  );

  // lane k holds byte k of every word
  for (genvar k = 0; k < LANE_NUM; k++) begin : lane_g
    lsu_lane_ram #(
      .ADDR_WD (ADDR_WD)
    ) u_lane (
      .i_clk   (i_clk),
      .i_we    (lane_we[k]),
      .i_waddr (word_idx),
      .i_wdata (lane_wdata[k*LANE_WD +: LANE_WD]),
      .o_rdata (rd_word[k*LANE_WD +: LANE_WD])
    );
  end

  lsu_load u_load (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_req      (i_req),
    .i_wen      (i_wen),
    .i_mem_op   (i_mem_op),
    .i_offset   (offset),
    .i_misalign (misalign),
    .i_rd_word  (rd_word),
    .o_rvalid   (o_rvalid),
    .o_rdata    (o_rdata),
    .o_err      (o_err)
  );

endmodule

/* source/lsu_pkg.sv */
// shared widths and op codes of the 64-bit data-memory slice; the word width is fixed by RV64

package lsu_pkg;

  // a memory word is one RV64 register wide
  localparam int DATA_WD  = 64;
  localparam int LANE_WD  = 8;                  // one byte per lane
  localparam int LANE_NUM = DATA_WD / LANE_WD;
  localparam int OFS_WD   = 3;                  // byte offset inside a word

  // funct3-style encoding of the access size
  // bit 0 set means zero-extend on a load and stores ignore it
  typedef enum logic [2:0] {
    MEM_LB   = 3'b000,
    MEM_LBU  = 3'b001,
    MEM_LH   = 3'b010,
    MEM_LHU  = 3'b011,
    MEM_LW   = 3'b100,
    MEM_LWU  = 3'b101,
    MEM_LD   = 3'b110,
    MEM_NONE = 3'b111                           // no access this cycle
  } mem_op_e;

endpackage

/* source/lsu_store.sv */
// store aligner; only naturally aligned accesses get a lane mask, any other one is flagged

module lsu_store (
  input  logic                         i_req,
  input  logic                         i_wen,
  input  lsu_pkg::mem_op_e             i_mem_op,
  input  logic [lsu_pkg::OFS_WD-1:0]   i_offset,
  input  logic [lsu_pkg::DATA_WD-1:0]  i_wdata,
  output logic [lsu_pkg::LANE_NUM-1:0] o_lane_we,
  output logic [lsu_pkg::DATA_WD-1:0]  o_lane_wdata,
  output logic                         o_misalign
);

  import lsu_pkg::*;

  logic [LANE_NUM-1:0] lane_mask;
  logic [DATA_WD-1:0]  shifted;

  // the mask is decoded for loads as well because misalign needs it
  always_comb begin
    lane_mask = '0;
    case (i_mem_op)
      MEM_LB, MEM_LBU: begin
        case (i_offset)
          3'h0:    lane_mask = 8'b0000_0001;
          3'h1:    lane_mask = 8'b0000_0010;
          3'h2:    lane_mask = 8'b0000_0100;
          3'h3:    lane_mask = 8'b0000_1000;
          3'h4:    lane_mask = 8'b0001_0000;
          3'h5:    lane_mask = 8'b0010_0000;
          3'h6:    lane_mask = 8'b0100_0000;
          3'h7:    lane_mask = 8'b1000_0000;
          default: lane_mask = '0;
        endcase
      end
      MEM_LH, MEM_LHU: begin
        case (i_offset)
          3'h0:    lane_mask = 8'b0000_0011;
          3'h2:    lane_mask = 8'b0000_1100;
          3'h4:    lane_mask = 8'b0011_0000;
          3'h6:    lane_mask = 8'b1100_0000;
          default: lane_mask = '0;      // odd offset splits the half
        endcase
      end
      MEM_LW, MEM_LWU: begin
        case (i_offset)
          3'h0:    lane_mask = 8'b0000_1111;
          3'h4:    lane_mask = 8'b1111_0000;
          default: lane_mask = '0;
        endcase
      end
      MEM_LD: begin
        if (i_offset == '0) begin
          lane_mask = 8'b1111_1111;
        end
      end
      default: lane_mask = '0;          // MEM_NONE touches nothing
    endcase
  end

  assign o_misalign = (i_mem_op != MEM_NONE) && (lane_mask == '0);

  // a misaligned store has an empty mask and so writes nothing
  assign o_lane_we = (i_req && i_wen) ? lane_mask : '0;

  // move the low bytes of the store data up to the addressed lane
  always_comb begin
    case (i_offset)
      3'h0:    shifted = i_wdata;
      3'h1:    shifted = {i_wdata[55:0], 8'h00};
      3'h2:    shifted = {i_wdata[47:0], 16'h0000};
      3'h3:    shifted = {i_wdata[39:0], 24'h00_0000};
      3'h4:    shifted = {i_wdata[31:0], 32'h0000_0000};
      3'h5:    shifted = {i_wdata[23:0], 40'h00_0000_0000};
      3'h6:    shifted = {i_wdata[15:0], 48'h0000_0000_0000};
      3'h7:    shifted = {i_wdata[7:0], 56'h00_0000_0000_0000};
      default: shifted = i_wdata;
    endcase
  end

  assign o_lane_wdata = shifted;

endmodule

/* verification/tb_lsu_mem.sv */
// drives lsu_mem_top with ADDR_WD 6; needs --assert and --timing and writes every word before the first load

module tb_lsu_mem;

  import lsu_pkg::*;

  localparam int AW    = 6;
  localparam int BYTES = 8 << AW;

  logic          clk;
  logic          rst_n;
  logic          req;
  logic          wen;
  mem_op_e       mem_op;
  logic [AW+2:0] addr;
  logic [63:0]   wdata;
  logic          rvalid;
  logic [63:0]   rdata;
  logic          err;

  logic [7:0]    ref_mem [BYTES];   // byte image of what the DUT should hold
  logic [63:0]   exp_q [$];         // one entry per outstanding load
  logic [31:0]   lfsr_state;
  logic          is_load_req;
  logic          is_mis_req;
  int            n_err;
  int            n_check;
  int            n_tpass;
  int            n_tfail;

  lsu_mem_top #(
    .ADDR_WD (AW)
  ) uut (
    .i_clk    (clk),
    .i_rst_n  (rst_n),
    .i_req    (req),
    .i_wen    (wen),
    .i_mem_op (mem_op),
    .i_addr   (addr),
    .i_wdata  (wdata),
    .o_rvalid (rvalid),
    .o_rdata  (rdata),
    .o_err    (err)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // taps of x^32 + x^22 + x^2 + x + 1 with one step per bit handed out
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_val(input int nbits);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      v = {v[62:0], lfsr_bit()};
    end
    return v;
  endfunction

  // the access must start on a multiple of its size in bytes
  function automatic logic [7:0] lane_mask(input mem_op_e op, input logic [2:0] ofs);
    int          size;
    logic [15:0] ones;
    case (op)
      MEM_LB, MEM_LBU: size = 1;
      MEM_LH, MEM_LHU: size = 2;
      MEM_LW, MEM_LWU: size = 4;
      MEM_LD:          size = 8;
      default:         size = 0;
    endcase
    if (size == 0 || (int'(ofs) % size) != 0) begin
      return 8'h00;
    end
    ones = (16'd1 << size) - 16'd1;
    return ones[7:0] << ofs;
  endfunction

  task automatic store_model(input logic [7:0] m, input logic [AW+2:0] a, input logic [63:0] d);
    logic [7:0]    sel;
    logic [AW+2:0] idx;
    int            k;
    for (int i = 0; i < 8; i++) begin
      sel = m >> i;
      if (sel[0]) begin
        idx = {a[AW+2:3], 3'b000} + 9'(i);
        k = i - int'(a[2:0]);            // byte k of the store data lands in lane i
        ref_mem[idx] = 8'(d >> (8 * k));
      end
    end
  endtask

  function automatic logic [63:0] load_expect(input mem_op_e op, input logic [AW+2:0] a);
    int            size;
    logic [2:0]    code;
    logic [AW+2:0] idx;
    logic [63:0]   v;
    logic [63:0]   top;
    size = $countones(lane_mask(op, a[2:0]));
    code = op;
    v = '0;
    if (size == 0) begin
      return '0;                         // misaligned loads come back as zero
    end
    for (int i = 0; i < size; i++) begin
      idx = a + 9'(i);
      v = v | (64'(ref_mem[idx]) << (8 * i));
    end
    top = v >> (8 * size - 1);
    if (!code[0] && top[0]) begin
      v = v | (~64'd0 << (8 * size));    // even codes sign-extend
    end
    return v;
  endfunction

  // one request in the cycle that starts at this falling edge
  task automatic issue(input logic is_wr, input mem_op_e op, input logic [AW+2:0] a,
                       input logic [63:0] d);
    @(negedge clk);
    req    = 1'b1;
    wen    = is_wr;
    mem_op = op;
    addr   = a;
    wdata  = d;
    if (is_wr) begin
      store_model(lane_mask(op, a[2:0]), a, d);
    end else if (op != MEM_NONE) begin
      exp_q.push_back(load_expect(op, a));
    end
  endtask

  task automatic idle();
    @(negedge clk);
    req    = 1'b0;
    wen    = 1'b0;
    mem_op = MEM_NONE;
    addr   = '0;
    wdata  = '0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%0t: timeout, %0d load results never arrived", $time, exp_q.size());
      n_err++;
      exp_q.delete();
    end
    repeat (2) @(negedge clk);         // the last error pulse gets its check
  endtask

  task automatic check_idle_outputs();
    assert (rvalid === 1'b0) else begin
      $display("Mismatch at %0t: o_rvalid expected 0, got %b", $time, rvalid);
      n_err++;
    end
    assert (err === 1'b0) else begin
      $display("Mismatch at %0t: o_err expected 0, got %b", $time, err);
      n_err++;
    end
    assert (rdata === 64'd0) else begin
      $display("Mismatch at %0t: o_rdata expected %h, got %h", $time, 64'd0, rdata);
      n_err++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (n_err == errs_before) begin
      n_tpass++;
      $display("test %s: passed", name);
    end else begin
      n_tfail++;
      $display("test %s: failed with %0d errors", name, n_err - errs_before);
    end
  endtask

  always_comb begin
    is_load_req = req && !wen && (mem_op != MEM_NONE);
    is_mis_req  = req && (mem_op != MEM_NONE) && (lane_mask(mem_op, addr[2:0]) == 8'h00);
  end

  load_gives_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    is_load_req |=> rvalid)
    else begin
      $display("%0t: o_rvalid missing in the cycle after a load", $time);
      n_err++;
    end

  rvalid_only_after_load: assert property (@(posedge clk) disable iff (!rst_n)
    !is_load_req |=> !rvalid)
    else begin
      $display("%0t: o_rvalid raised after a store, MEM_NONE or idle cycle", $time);
      n_err++;
    end

  misalign_gives_err: assert property (@(posedge clk) disable iff (!rst_n)
    is_mis_req |=> err)
    else begin
      $display("%0t: o_err missing in the cycle after a misaligned request", $time);
      n_err++;
    end

  err_only_after_misalign: assert property (@(posedge clk) disable iff (!rst_n)
    !is_mis_req |=> !err)
    else begin
      $display("%0t: o_err raised without a misaligned request", $time);
      n_err++;
    end

  // outputs settle after the rising edge, so the falling edge sees them stable
  always @(negedge clk) begin : rdata_monitor
    logic [63:0] exp_val;
    if (rst_n && rvalid) begin
      assert (exp_q.size() != 0) else begin
        $display("%0t: o_rvalid high with no load outstanding", $time);
        n_err++;
      end
      if (exp_q.size() != 0) begin
        exp_val = exp_q.pop_front();
        n_check++;
        assert (rdata === exp_val) else begin
          $display("Mismatch at %0t: o_rdata expected %h, got %h", $time, exp_val, rdata);
          n_err++;
        end
      end
    end
  end

  initial begin : main_seq
    int            errs_before;
    mem_op_e       op;
    logic [AW-1:0] word;
    logic [AW+2:0] a;
    logic [2:0]    kind;
    rst_n      = 1'b0;
    req        = 1'b0;
    wen        = 1'b0;
    mem_op     = MEM_NONE;
    addr       = '0;
    wdata      = '0;
    lfsr_state = 32'h839f;
    n_err      = 0;
    n_check    = 0;
    n_tpass    = 0;
    n_tfail    = 0;
    for (int i = 0; i < BYTES; i++) begin
      ref_mem[i] = 8'h00;
    end

    errs_before = n_err;
    @(negedge clk);
    check_idle_outputs();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_idle_outputs();
    report_test("1 reset values", errs_before);

    // fill every word first, then overwrite parts and read the whole word back
    errs_before = n_err;
    for (int w = 0; w < (1 << AW); w++) begin
      issue(1'b1, MEM_LD, {AW'(w), 3'b000}, rand_val(64));
    end
    for (int c = 0; c < 6; c++) begin
      for (int o = 0; o < 8; o++) begin
        op = mem_op_e'(3'(c));
        if (lane_mask(op, 3'(o)) != 8'h00) begin
          word = AW'(rand_val(AW));
          issue(1'b1, op, {word, 3'(o)}, rand_val(64));
          issue(1'b0, MEM_LD, {word, 3'b000}, 64'd0);
        end
      end
    end
    idle();
    drain();
    report_test("2 aligned stores", errs_before);

    errs_before = n_err;
    for (int c = 0; c < 7; c++) begin
      for (int o = 0; o < 8; o++) begin
        op = mem_op_e'(3'(c));
        if (lane_mask(op, 3'(o)) != 8'h00) begin
          issue(1'b0, op, {AW'(rand_val(AW)), 3'(o)}, 64'd0);
        end
      end
    end
    idle();
    drain();
    report_test("3 aligned loads", errs_before);

    errs_before = n_err;
    for (int c = 0; c < 7; c++) begin
      for (int o = 0; o < 8; o++) begin
        op = mem_op_e'(3'(c));
        if (lane_mask(op, 3'(o)) == 8'h00) begin
          word = AW'(rand_val(AW));
          issue(1'b1, op, {word, 3'(o)}, rand_val(64));
          issue(1'b0, MEM_LD, {word, 3'b000}, 64'd0);
          issue(1'b0, op, {word, 3'(o)}, 64'd0);
        end
      end
    end
    word = AW'(rand_val(AW));
    issue(1'b1, MEM_NONE, {word, 3'b000}, rand_val(64));
    issue(1'b0, MEM_NONE, {word, 3'b000}, 64'd0);
    issue(1'b0, MEM_LD, {word, 3'b000}, 64'd0);
    idle();
    drain();
    report_test("4 misaligned and MEM_NONE", errs_before);

    errs_before = n_err;
    for (int n = 0; n < 400; n++) begin
      kind = 3'(rand_val(3));
      a    = (AW + 3)'(rand_val(AW + 3));
      op   = mem_op_e'(3'(rand_val(3)));
      if (kind == 3'd0) begin
        idle();
      end else if (kind < 3'd4) begin
        issue(1'b1, op, a, rand_val(64));
        if (lfsr_bit()) begin
          issue(1'b0, MEM_LD, {a[AW+2:3], 3'b000}, 64'd0);  // read back right after the write
        end
      end else begin
        issue(1'b0, op, a, 64'd0);
      end
    end
    idle();
    drain();
    report_test("5 random mix", errs_before);

    $display("summary: %0d tests passed, %0d tests failed, %0d read checks, %0d errors",
             n_tpass, n_tfail, n_check, n_err);
    if (n_err == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
